//--- common/uart_pkg.sv
package uart_pkg;

    // command bus geometry.
    localparam int mmio_width = 32;
    localparam int byte_width = 8;

    // ring buffer of 256 bytes held as 64 words.
    localparam int buffer_bytes = 256;
    localparam int buffer_words = buffer_bytes / (mmio_width / byte_width);
    localparam int word_index_width = $clog2(buffer_words);
    localparam int ptr_width = $clog2(buffer_bytes);

    typedef logic [mmio_width-1:0] mmio_addr_t;
    typedef logic [mmio_width-1:0] mmio_data_t;

    // 8-bit pointers wrap around the ring on their own.
    typedef logic [ptr_width-1:0] queue_ptr_t;
    typedef logic [byte_width-1:0] tx_byte_t;
    typedef logic [word_index_width-1:0] word_index_t;

    // register map.
    localparam mmio_addr_t queue_head_offset = 32'h0000_0100;
    localparam mmio_addr_t queue_tail_offset = 32'h0000_0104;

    // drain engine.
    typedef enum logic [1:0] {
        drain_idle,
        drain_fetch,
        drain_wait_ready
    } drain_state_t;

    // serial frame phases.
    typedef enum logic [1:0] {
        serial_idle,
        serial_start,
        serial_data,
        serial_stop
    } serial_state_t;

    // data bits per frame.
    localparam int frame_data_bits = byte_width;

endpackage

//--- design/uart_serializer.sv
`timescale 1ns/100ps

module uart_serializer import uart_pkg::*; #(
    parameter int clocks_per_bit = 10
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     tx_start,
    input  tx_byte_t tx_data,
    output logic     tx_ready,
    output logic     uart_tx
);

    localparam int count_width = $clog2(clocks_per_bit + 1);
    localparam int index_width = $clog2(frame_data_bits);

    serial_state_t state;
    logic [count_width-1:0] baud_count;
    logic [index_width-1:0] bit_index;
    tx_byte_t shifter;
    logic bit_end;

    // last clock of the current bit period.
    assign bit_end = (baud_count == count_width'(clocks_per_bit - 1));

    assign tx_ready = (state == serial_idle);

    // line level follows the frame phase.
    always_comb begin
        case (state)
            serial_start: uart_tx = 1'b0;
            serial_data:  uart_tx = shifter[0];
            default:      uart_tx = 1'b1;
        endcase
    end

    // baud counter restarts at each bit boundary.
    always_ff @(posedge clk) begin
        if (reset) begin
            baud_count <= '0;
        end else if (state == serial_idle || bit_end) begin
            baud_count <= '0;
        end else begin
            baud_count <= baud_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= serial_idle;
            bit_index <= '0;
        end else begin
            case (state)
                serial_idle: begin
                    if (tx_start) begin
                        state <= serial_start;
                    end
                end
                serial_start: begin
                    if (bit_end) begin
                        state     <= serial_data;
                        bit_index <= '0;
                    end
                end
                serial_data: begin
                    if (bit_end) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == index_width'(frame_data_bits - 1)) begin
                            state <= serial_stop;
                        end
                    end
                end
                serial_stop: begin
                    if (bit_end) begin
                        state <= serial_idle;
                    end
                end
                default: state <= serial_idle;
            endcase
        end
    end

    // lsb first, so shift right after each data bit.
    always_ff @(posedge clk) begin
        if (state == serial_idle && tx_start) begin
            shifter <= tx_data;
        end else if (state == serial_data && bit_end) begin
            shifter <= {1'b0, shifter[frame_data_bits-1:1]};
        end
    end

endmodule

//--- design/uart_tx_top.sv
`timescale 1ns/100ps

module uart_tx_top import uart_pkg::*; #(
    parameter int clk_freq_mhz = 27,
    parameter int baud_rate = 115200
) (
    input  logic       clk,
    input  logic       reset,

    // command port.
    input  logic       cmd_start,
    input  logic       cmd_write,
    output logic       cmd_ready,
    input  mmio_addr_t addr,
    input  mmio_data_t wdata,
    output mmio_data_t rdata,
    output logic       rdata_valid,

    // serial line.
    output logic       uart_tx
);

    // whole clocks per bit, rounded down.
    localparam int clocks_per_bit = (clk_freq_mhz * 1_000_000) / baud_rate;

    mmio_data_t queue_rdata;
    logic queue_rdata_valid;
    logic queue_cmd_ready;
    logic queue_line;

    uart_tx_queue #(
        .clocks_per_bit(clocks_per_bit)
    ) queue_inst (
        .clk        (clk),
        .reset      (reset),
        .cmd_start  (cmd_start),
        .cmd_write  (cmd_write),
        .cmd_ready  (queue_cmd_ready),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (queue_rdata),
        .rdata_valid(queue_rdata_valid),
        .uart_tx    (queue_line)
    );

    assign cmd_ready = queue_cmd_ready;
    assign rdata = queue_rdata;
    assign rdata_valid = queue_rdata_valid;
    assign uart_tx = queue_line;

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    --top-module tb_uart_tx \
    -f sim.f \
    -o tb_uart_tx_sim

status=0
./obj_dir/tb_uart_tx_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, exit status $status"
exit 1

//--- sim.f
common/uart_pkg.sv
design/uart_serializer.sv
uart_tx_queue/uart_tx_queue.sv
design/uart_tx_top.sv
testbench/uart_line_monitor.sv
testbench/tb_uart_tx.sv

//--- testbench/tb_uart_tx.sv
`timescale 1ns/100ps

module tb_uart_tx import uart_pkg::*; ();

    localparam int clk_freq_mhz = 250;
    localparam int baud_rate = 25_000_000;
    // 250 MHz at 25 Mbaud gives 10 clocks per bit.
    localparam int clocks_per_bit = 10;
    localparam int clk_period_ns = 4;

    // 300 frames of 100 cycles plus a quarter for gaps and bus traffic.
    localparam int frame_budget = 300;
    localparam int frame_cycles = 100;
    localparam int nominal_ns = frame_budget * frame_cycles * clk_period_ns;
    localparam int watchdog_ns = nominal_ns + nominal_ns / 4;

    logic clk = 1'b0;
    logic reset;
    logic cmd_start;
    logic cmd_write;
    logic cmd_ready;
    mmio_addr_t addr;
    mmio_data_t wdata;
    mmio_data_t rdata;
    logic rdata_valid;
    logic uart_tx;

    tx_byte_t rx_byte;
    logic rx_valid;
    logic frame_error;

    int seed = 13;
    tx_byte_t ring_model [buffer_bytes];
    tx_byte_t expected [$];
    tx_byte_t received [$];
    queue_ptr_t sw_tail;

    always #(clk_period_ns / 2) clk = ~clk;

    uart_tx_top #(
        .clk_freq_mhz(clk_freq_mhz),
        .baud_rate   (baud_rate)
    ) uart_tx_inst (
        .clk        (clk),
        .reset      (reset),
        .cmd_start  (cmd_start),
        .cmd_write  (cmd_write),
        .cmd_ready  (cmd_ready),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .rdata_valid(rdata_valid),
        .uart_tx    (uart_tx)
    );

    uart_line_monitor #(
        .clocks_per_bit(clocks_per_bit)
    ) line_monitor_inst (
        .clk        (clk),
        .reset      (reset),
        .uart_tx    (uart_tx),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .frame_error(frame_error)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    always @(posedge clk) begin
        if (frame_error) begin
            $display("line monitor saw a bad start or stop bit");
            abort_run();
        end else if (rx_valid) begin
            received.push_back(rx_byte);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("run timed out after %0d ns without finishing the tests", watchdog_ns);
        abort_run();
    end

    task automatic compare_data(input string test_name, input mmio_data_t expected_value,
                                input mmio_data_t actual_value);
        if (actual_value !== expected_value) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h",
                     test_name, expected_value, actual_value);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string test_name, input tx_byte_t expected_value,
                                input tx_byte_t actual_value);
        if (actual_value !== expected_value) begin
            $display("FAIL %s expected 0x%02h actual 0x%02h",
                     test_name, expected_value, actual_value);
            abort_run();
        end
    endtask

    // bus tasks start and end 1 ns after a rising edge.
    task automatic bus_write(input mmio_addr_t target, input mmio_data_t value);
        cmd_start = 1'b1;
        cmd_write = 1'b1;
        addr = target;
        wdata = value;
        if (!cmd_ready) begin
            $display("command port was not ready for a write to 0x%08h", target);
            abort_run();
        end
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
    endtask

    task automatic bus_read(input mmio_addr_t target, output mmio_data_t value);
        cmd_start = 1'b1;
        cmd_write = 1'b0;
        addr = target;
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
        if (!rdata_valid) begin
            $display("read data valid did not rise one cycle after a read of 0x%08h", target);
            abort_run();
        end
        value = rdata;
    endtask

    task automatic store_word(input int word_idx, input mmio_data_t value);
        queue_ptr_t slot;
        bus_write(mmio_addr_t'(word_idx * 4), value);
        for (int lane = 0; lane < 4; lane++) begin
            slot = queue_ptr_t'(word_idx * 4 + lane);
            ring_model[slot] = tx_byte_t'(value >> (8 * lane));
        end
    endtask

    // expected bytes come from the model at the old tail positions.
    task automatic advance_tail(input int count);
        for (int i = 0; i < count; i++) begin
            expected.push_back(ring_model[sw_tail]);
            sw_tail = sw_tail + queue_ptr_t'(1);
        end
        bus_write(queue_tail_offset, mmio_data_t'(sw_tail));
    endtask

    task automatic wait_for_bytes(input int count);
        while (received.size() < count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_stream(input string test_name);
        wait_for_bytes(expected.size());
        for (int i = 0; i < expected.size(); i++) begin
            compare_byte(test_name, expected[i], received[i]);
        end
        expected.delete();
        received.delete();
    endtask

    task automatic check_head_at_tail(input string test_name);
        mmio_data_t value;
        bus_read(queue_head_offset, value);
        compare_data(test_name, mmio_data_t'(sw_tail), value);
    endtask

    task automatic test_reset_state();
        mmio_data_t value;
        if (uart_tx !== 1'b1 || rdata_valid !== 1'b0) begin
            $display("line not idle high or read valid set after reset");
            abort_run();
        end
        bus_read(queue_head_offset, value);
        compare_data("reset_state head", '0, value);
        bus_read(queue_tail_offset, value);
        compare_data("reset_state tail", '0, value);
    endtask

    task automatic test_buffer_readback();
        int words [4];
        mmio_data_t value;
        words = '{0, 7, 33, 63};
        foreach (words[i]) begin
            value = $random(seed);
            store_word(words[i], value);
        end
        foreach (words[i]) begin
            bus_read(mmio_addr_t'(words[i] * 4), value);
            compare_data("buffer_readback", {ring_model[queue_ptr_t'(words[i] * 4 + 3)],
                                             ring_model[queue_ptr_t'(words[i] * 4 + 2)],
                                             ring_model[queue_ptr_t'(words[i] * 4 + 1)],
                                             ring_model[queue_ptr_t'(words[i] * 4)]}, value);
        end
        bus_write(queue_head_offset, 32'h0000_0055);
        bus_read(queue_head_offset, value);
        compare_data("buffer_readback head write", '0, value);
    endtask

    task automatic test_byte_order();
        store_word(0, 32'hF00F_3CA5);
        advance_tail(4);
        check_stream("byte_order");
        check_head_at_tail("byte_order head");
    endtask

    task automatic test_append_while_busy();
        store_word(1, 32'h7766_5544);
        store_word(2, 32'hBBAA_9988);
        advance_tail(2);
        while (uart_tx) begin
            @(posedge clk);
            #1;
        end
        advance_tail(3);
        repeat (20) @(posedge clk);
        #1;
        advance_tail(3);
        check_stream("append_while_busy");
        check_head_at_tail("append_while_busy head");
    endtask

    // 8 steps of 33 bytes pass the end of the ring once.
    task automatic test_wraparound();
        mmio_data_t value;
        for (int w = 0; w < buffer_words; w++) begin
            value = $random(seed);
            store_word(w, value);
        end
        for (int step = 0; step < 8; step++) begin
            advance_tail(33);
            wait_for_bytes(expected.size());
        end
        check_stream("wraparound");
        check_head_at_tail("wraparound head");
    endtask

    initial begin
        reset = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        addr = '0;
        wdata = '0;
        sw_tail = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_buffer_readback();
        test_byte_order();
        test_append_while_busy();
        test_wraparound();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- testbench/uart_line_monitor.sv
`timescale 1ns/100ps

module uart_line_monitor import uart_pkg::*; #(
    parameter int clocks_per_bit = 10
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     uart_tx,
    output tx_byte_t rx_byte,
    output logic     rx_valid,
    output logic     frame_error
);

    tx_byte_t shift;

    // falling clock edges keep samples away from line transitions.
    task automatic skip_clocks(input int count);
        repeat (count) @(negedge clk);
    endtask

    initial begin
        rx_byte = '0;
        rx_valid = 1'b0;
        frame_error = 1'b0;
        shift = '0;
        @(negedge reset);
        forever begin
            @(negedge uart_tx);
            // middle of the start bit.
            skip_clocks(clocks_per_bit / 2);
            if (uart_tx) begin
                frame_error = 1'b1;
            end
            // lsb arrives first, so shift in from the top.
            for (int i = 0; i < frame_data_bits; i++) begin
                skip_clocks(clocks_per_bit);
                shift = {uart_tx, shift[frame_data_bits-1:1]};
            end
            skip_clocks(clocks_per_bit);
            if (!uart_tx) begin
                frame_error = 1'b1;
            end
            rx_byte = shift;
            rx_valid = 1'b1;
            skip_clocks(1);
            rx_valid = 1'b0;
            frame_error = 1'b0;
        end
    end

endmodule

//--- uart_tx_queue/uart_tx_queue.sv
`timescale 1ns/100ps

module uart_tx_queue import uart_pkg::*; #(
    parameter int clocks_per_bit = 10
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       cmd_start,
    input  logic       cmd_write,
    output logic       cmd_ready,
    input  mmio_addr_t addr,
    input  mmio_data_t wdata,
    output mmio_data_t rdata,
    output logic       rdata_valid,

    output logic       uart_tx
);

    mmio_data_t buffer [buffer_words];

    queue_ptr_t queue_head;
    queue_ptr_t queue_tail;

    logic is_head_addr;
    logic is_tail_addr;
    logic is_buffer_addr;
    word_index_t buffer_index;

    logic cmd_wr;
    logic cmd_rd;

    drain_state_t drain_state;
    mmio_data_t fetched_word;
    word_index_t head_word;
    logic [1:0] head_lane;

    logic tx_start;
    tx_byte_t tx_data;
    logic tx_ready;

    // every command is taken on the cycle it is presented.
    assign cmd_ready = 1'b1;

    assign is_head_addr = (addr == queue_head_offset);
    assign is_tail_addr = (addr == queue_tail_offset);
    assign is_buffer_addr = !is_head_addr && !is_tail_addr;
    assign buffer_index = addr[word_index_width+1:2];

    assign cmd_wr = cmd_start && cmd_write;
    assign cmd_rd = cmd_start && !cmd_write;

    // word holding the byte at head, and its byte lane.
    assign head_word = queue_head[ptr_width-1:2];
    assign head_lane = queue_head[1:0];

    // buffer writes.
    always_ff @(posedge clk) begin
        if (cmd_wr && is_buffer_addr) begin
            buffer[buffer_index] <= wdata;
        end
    end

    // tail is software owned and head writes are dropped.
    always_ff @(posedge clk) begin
        if (reset) begin
            queue_tail <= '0;
        end else if (cmd_wr && is_tail_addr) begin
            queue_tail <= wdata[ptr_width-1:0];
        end
    end

    // read data lands one cycle after the command.
    always_ff @(posedge clk) begin
        if (cmd_rd) begin
            if (is_head_addr) begin
                rdata <= mmio_data_t'(queue_head);
            end else if (is_tail_addr) begin
                rdata <= mmio_data_t'(queue_tail);
            end else begin
                rdata <= buffer[buffer_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cmd_rd;
        end
    end

    // drain engine moves one byte per pass.
    always_ff @(posedge clk) begin
        if (reset) begin
            drain_state <= drain_idle;
            queue_head  <= '0;
            tx_start    <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (drain_state)
                drain_idle: begin
                    if (queue_tail != queue_head) begin
                        drain_state <= drain_fetch;
                    end
                end
                drain_fetch: begin
                    drain_state <= drain_wait_ready;
                end
                drain_wait_ready: begin
                    // hold head until the serializer frees up.
                    if (tx_ready) begin
                        tx_start    <= 1'b1;
                        queue_head  <= queue_head + 1'b1;
                        drain_state <= drain_idle;
                    end
                end
                default: drain_state <= drain_idle;
            endcase
        end
    end

    // word fetch and byte lane select.
    always_ff @(posedge clk) begin
        if (drain_state == drain_idle && queue_tail != queue_head) begin
            fetched_word <= buffer[head_word];
        end
        if (drain_state == drain_fetch) begin
            case (head_lane)
                2'd0: tx_data <= fetched_word[7:0];
                2'd1: tx_data <= fetched_word[15:8];
                2'd2: tx_data <= fetched_word[23:16];
                default: tx_data <= fetched_word[31:24];
            endcase
        end
    end

    uart_serializer #(
        .clocks_per_bit(clocks_per_bit)
    ) serializer_inst (
        .clk     (clk),
        .reset   (reset),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .tx_ready(tx_ready),
        .uart_tx (uart_tx)
    );

endmodule
